/* Makefile */
# Verilator build and run for the memory game testbench

TOP = memory_game_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/memory_game_tb_table.svh */
`ifndef memory_game_tb_table_svh
`define memory_game_tb_table_svh

// Kind of game that one row plays
typedef enum logic [1:0] {
   kind_win     = 2'd0,
   kind_error   = 2'd1,
   kind_timeout = 2'd2
} game_kind_t;

// Fault position is unused for a win
// A fault play of round + 1 means the extra press after that round
typedef struct packed {
   game_kind_t              kind;
   memory_game_pkg::index_t fault_round;
   memory_game_pkg::index_t fault_play;
   logic                    exp_won;
   logic                    exp_lost;
   logic                    exp_timed_out;
} test_row_t;

localparam int num_rows = 8;

// kind, fault round, fault play, won, lost, timed_out
localparam test_row_t test_table [num_rows] = '{
   '{kind_win,     4'd0, 4'd0, 1'b1, 1'b0, 1'b0},
   '{kind_error,   4'd0, 4'd0, 1'b0, 1'b1, 1'b0},
   '{kind_win,     4'd0, 4'd0, 1'b1, 1'b0, 1'b0},
   '{kind_error,   4'd2, 4'd1, 1'b0, 1'b1, 1'b0},
   '{kind_timeout, 4'd2, 4'd3, 1'b0, 1'b1, 1'b1},
   '{kind_timeout, 4'd0, 4'd0, 1'b0, 1'b1, 1'b1},
   '{kind_win,     4'd0, 4'd0, 1'b1, 1'b0, 1'b0},
   '{kind_error,   4'd3, 4'd3, 1'b0, 1'b1, 1'b0}
};

`endif

/* dv/memory_game_tb.sv */
`timescale 1ns/10ps

module memory_game_tb;

   import memory_game_pkg::*;

   `include "memory_game_tb_table.svh"

   localparam time clock_period   = 100;
   localparam int  show_cycles    = 8;
   localparam int  timeout_cycles = 40;
   localparam int  num_rounds     = 4;
   localparam int  done_limit     = timeout_cycles + 20;
   // Rows x 80 presses x 10 cycles, plus margin
   localparam time watchdog_ns    = num_rows * 80 * 10 * clock_period + 200 * clock_period;

   logic    clock;
   logic    reset;
   logic    start;
   button_t buttons;
   button_t leds;
   logic    won;
   logic    lost;
   logic    done;
   logic    timed_out;

   integer  seed;
   int      errors;
   int      checks;
   button_t model_seq [seq_depth];

   memory_game #(
      .show_cycles    (show_cycles),
      .timeout_cycles (timeout_cycles),
      .num_rounds     (num_rounds)
   ) u_memory_game (
      .clock     (clock),
      .reset     (reset),
      .start     (start),
      .buttons   (buttons),
      .leds      (leds),
      .won       (won),
      .lost      (lost),
      .done      (done),
      .timed_out (timed_out)
   );

   initial begin
      clock = 1'b0;
   end

   always #(clock_period / 2) clock = ~clock;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic step_cycle();
      @(posedge clock);
      #10;
   endtask

   task automatic check_value(input string what, input button_t got, input button_t expected);
      checks++;
      assert (got === expected) else begin
         errors++;
         $display("error at %0t: %s is %b, expected %b", $time, what, got, expected);
      end
   endtask

   // Hold for 4 cycles, release for 6
   task automatic press_button(input button_t value);
      buttons = value;
      repeat (4) begin
         #40;
         check_value("leds while pressing", leds, value);
         @(posedge clock);
         #10;
      end
      buttons = '0;
      repeat (6) step_cycle();
   endtask

   task automatic start_game();
      int  cycles;
      logic seen;
      start = 1'b1;
      step_cycle();
      start = 1'b0;
      cycles = 0;
      seen = 1'b0;
      while (!seen && cycles < 12) begin
         step_cycle();
         cycles++;
         seen = (leds == 4'b0001);
      end
      checks++;
      assert (seen) else begin
         errors++;
         $display("leds never showed the first entry after start");
      end
      // Show phase ends, then the first wait begins
      cycles = 0;
      while (leds != 4'b0000 && cycles < show_cycles + 4) begin
         step_cycle();
         cycles++;
      end
      check_value("leds after the show phase", leds, 4'b0000);
   endtask

   task automatic play_game(input test_row_t row);
      logic   stop;
      integer rnd;
      stop = 1'b0;
      for (int r = 0; r < num_rounds && !stop; r++) begin
         for (int p = 0; p <= r + 1 && !stop; p++) begin
            if (row.kind != kind_win && index_t'(r) == row.fault_round &&
                index_t'(p) == row.fault_play) begin
               // A wrong value is the entry rotated by one button
               if (row.kind == kind_error) begin
                  press_button({model_seq[p][2:0], model_seq[p][3]});
               end
               stop = 1'b1;
            end else if (p <= r) begin
               press_button(model_seq[p]);
            end else if (r < num_rounds - 1) begin
               rnd = $random(seed);
               model_seq[r + 1] = 4'b0001 << rnd[1:0];
               press_button(model_seq[r + 1]);
            end
         end
      end
   endtask

   task automatic finish_game(input int row_num, input test_row_t row);
      int cycles;
      cycles = 0;
      while (!done && cycles < done_limit) begin
         step_cycle();
         cycles++;
      end
      checks++;
      assert (done) else begin
         errors++;
         $display("game of row %0d did not end within %0d cycles", row_num, done_limit);
      end
      check_value("won", {3'b000, won}, {3'b000, row.exp_won});
      check_value("lost", {3'b000, lost}, {3'b000, row.exp_lost});
      check_value("timed_out", {3'b000, timed_out}, {3'b000, row.exp_timed_out});
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      seed    = 21364;
      errors  = 0;
      checks  = 0;
      reset   = 1'b1;
      start   = 1'b0;
      buttons = '0;
      for (int i = 0; i < seq_depth; i++) begin
         model_seq[i] = '0;
      end
      model_seq[0] = 4'b0001;

      repeat (8) @(posedge clock);
      #10;
      reset = 1'b0;
      step_cycle();
      check_value("won after reset", {3'b000, won}, 4'b0000);
      check_value("lost after reset", {3'b000, lost}, 4'b0000);
      check_value("done after reset", {3'b000, done}, 4'b0000);
      check_value("timed_out after reset", {3'b000, timed_out}, 4'b0000);
      check_value("leds after reset", leds, 4'b0000);

      // Each game starts from the final state of the one before
      for (int i = 0; i < num_rows; i++) begin
         start_game();
         play_game(test_table[i]);
         finish_game(i, test_table[i]);
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired, the tests did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* hw/game_control.sv */
`timescale 1ns/10ps

module game_control (
   input  logic                     clock,
   input  logic                     reset,
   input  logic                     start,
   input  memory_game_pkg::status_t status,
   input  logic                     show_done,
   input  logic                     idle_expired,
   output memory_game_pkg::ctrl_t   ctrl,
   output logic                     show_clear,
   output logic                     show_enable,
   output logic                     idle_clear,
   output logic                     idle_enable,
   output logic                     won,
   output logic                     lost,
   output logic                     done,
   output logic                     timed_out
);

   import memory_game_pkg::*;

   state_t state;
   state_t state_next;

   // ----------------------------------------
   // State register
   // ----------------------------------------
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= state_next;
      end
   end

   // ----------------------------------------
   // Next state
   // ----------------------------------------
   always_comb begin
      state_next = state;
      case (state)
         idle: begin
            if (start) begin
               state_next = init;
            end
         end
         init:        state_next = show;
         show: begin
            if (show_done) begin
               state_next = round_start;
            end
         end
         round_start: state_next = wait_press;
         // Timeout checked before the press
         wait_press: begin
            if (idle_expired) begin
               state_next = final_timeout;
            end else if (status.press) begin
               state_next = register_press;
            end
         end
         register_press: state_next = compare;
         compare: begin
            if (!status.match) begin
               state_next = final_error;
            end else if (status.round_end) begin
               state_next = last_check;
            end else begin
               state_next = next_play;
            end
         end
         next_play: state_next = wait_press;
         last_check: begin
            if (status.game_end) begin
               state_next = final_win;
            end else begin
               state_next = wait_extra;
            end
         end
         wait_extra: begin
            if (idle_expired) begin
               state_next = final_timeout;
            end else if (status.press) begin
               state_next = register_extra;
            end
         end
         register_extra: state_next = next_round;
         next_round:     state_next = round_start;
         // Results hold until a new start
         final_win, final_error, final_timeout: begin
            if (start) begin
               state_next = init;
            end
         end
         default: state_next = idle;
      endcase
   end

   // ----------------------------------------
   // Moore outputs
   // ----------------------------------------
   always_comb begin
      ctrl.clear_play  = state inside {idle, init, round_start};
      ctrl.count_play  = state inside {next_play, register_extra};
      ctrl.clear_round = state inside {idle, init};
      ctrl.count_round = (state == next_round);
      ctrl.clear_guess = state inside {idle, init};
      ctrl.load_guess  = state inside {register_press, register_extra};
      ctrl.write_seq   = (state == next_round);
      ctrl.show_phase  = (state == show);
   end

   // Timer strobes
   assign show_clear  = state inside {idle, init};
   assign show_enable = (state == show);
   // Every wait starts from zero
   assign idle_clear  = state inside {idle, init, register_press, register_extra};
   assign idle_enable = state inside {wait_press, wait_extra};

   // Game result
   assign won       = (state == final_win);
   assign lost      = state inside {final_error, final_timeout};
   assign done      = state inside {final_win, final_error, final_timeout};
   assign timed_out = (state == final_timeout);

endmodule

/* hw/game_datapath.sv */
`timescale 1ns/10ps

module game_datapath #(
   parameter int num_rounds = 16
) (
   input  logic                      clock,
   input  logic                      reset,
   input  memory_game_pkg::ctrl_t    ctrl,
   input  memory_game_pkg::button_t  buttons,
   output memory_game_pkg::status_t  status,
   output memory_game_pkg::button_t  seq_entry
);

   import memory_game_pkg::*;

   localparam index_t last_round = index_t'(num_rounds - 1);

   index_t  play_index;
   index_t  round_index;
   button_t guess;
   logic    any_button;
   logic    press_q0;
   logic    press_q1;

   // ----------------------------------------
   // Play and round counters
   // ----------------------------------------
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         play_index <= '0;
      end else if (ctrl.clear_play) begin
         play_index <= '0;
      end else if (ctrl.count_play) begin
         play_index <= play_index + 1'b1;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         round_index <= '0;
      end else if (ctrl.clear_round) begin
         round_index <= '0;
      end else if (ctrl.count_round) begin
         round_index <= round_index + 1'b1;
      end
   end

   // ----------------------------------------
   // Guess register and press detection
   // ----------------------------------------
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         guess <= '0;
      end else if (ctrl.clear_guess) begin
         guess <= '0;
      end else if (ctrl.load_guess) begin
         guess <= buttons;
      end
   end

   // Any button held counts as activity
   assign any_button = |buttons;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         press_q0 <= 1'b0;
         press_q1 <= 1'b0;
      end else begin
         press_q0 <= any_button;
         press_q1 <= press_q0;
      end
   end

   // Sequence store, addressed by the play index
   sequence_memory u_sequence_memory (
      .clock (clock),
      .write (ctrl.write_seq),
      .addr  (play_index),
      .wdata (guess),
      .rdata (seq_entry)
   );

   // Flags for the FSM
   always_comb begin
      status.press     = press_q0 & ~press_q1;
      status.match     = (guess == seq_entry);
      status.round_end = (play_index == round_index);
      status.game_end  = (round_index == last_round);
   end

endmodule

/* hw/game_timer.sv */
`timescale 1ns/10ps

module game_timer #(
   parameter int limit = 1000
) (
   input  logic clock,
   input  logic reset,
   input  logic clear,
   input  logic enable,
   output logic expired
);

   localparam int cnt_w = (limit > 0) ? $clog2(limit + 1) : 1;
   localparam logic [cnt_w-1:0] last_count = cnt_w'(limit);

   logic [cnt_w-1:0] count;

   // Clear wins over enable, count parks at the limit
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (enable && (count != last_count)) begin
         count <= count + 1'b1;
      end
   end

   // Only flagged while the timer is running
   assign expired = enable && (count == last_count);

endmodule

/* hw/memory_game.sv */
`timescale 1ns/10ps

module memory_game #(
   parameter int show_cycles    = 1000,
   parameter int timeout_cycles = 50000,
   parameter int num_rounds     = 16
) (
   input  logic                     clock,
   input  logic                     reset,
   input  logic                     start,
   input  memory_game_pkg::button_t buttons,
   output memory_game_pkg::button_t leds,
   output logic                     won,
   output logic                     lost,
   output logic                     done,
   output logic                     timed_out
);

   import memory_game_pkg::*;

   ctrl_t   ctrl;
   status_t status;
   button_t seq_entry;
   logic    show_clear;
   logic    show_enable;
   logic    show_done;
   logic    idle_clear;
   logic    idle_enable;
   logic    idle_expired;

   // ----------------------------------------
   // Control and datapath
   // ----------------------------------------
   game_control u_game_control (
      .clock        (clock),
      .reset        (reset),
      .start        (start),
      .status       (status),
      .show_done    (show_done),
      .idle_expired (idle_expired),
      .ctrl         (ctrl),
      .show_clear   (show_clear),
      .show_enable  (show_enable),
      .idle_clear   (idle_clear),
      .idle_enable  (idle_enable),
      .won          (won),
      .lost         (lost),
      .done         (done),
      .timed_out    (timed_out)
   );

   game_datapath #(
      .num_rounds (num_rounds)
   ) u_game_datapath (
      .clock     (clock),
      .reset     (reset),
      .ctrl      (ctrl),
      .buttons   (buttons),
      .status    (status),
      .seq_entry (seq_entry)
   );

   // ----------------------------------------
   // Show phase and inactivity timers
   // ----------------------------------------
   game_timer #(
      .limit (show_cycles)
   ) u_show_timer (
      .clock   (clock),
      .reset   (reset),
      .clear   (show_clear),
      .enable  (show_enable),
      .expired (show_done)
   );

   game_timer #(
      .limit (timeout_cycles)
   ) u_idle_timer (
      .clock   (clock),
      .reset   (reset),
      .clear   (idle_clear),
      .enable  (idle_enable),
      .expired (idle_expired)
   );

   // Play index is 0 in the show phase, so this lights entry 0
   assign leds = ctrl.show_phase ? (buttons | seq_entry) : buttons;

endmodule

/* hw/memory_game_pkg.sv */
package memory_game_pkg;

   // ----------------------------------------
   // Widths and basic types
   // ----------------------------------------
   localparam int button_w  = 4;
   localparam int seq_depth = 16;

   typedef logic [button_w-1:0] button_t;
   typedef logic [3:0]          index_t;

   // Game FSM states
   typedef enum logic [3:0] {
      idle           = 4'h0,
      init           = 4'h1,
      round_start    = 4'h2,
      wait_press     = 4'h3,
      register_press = 4'h4,
      compare        = 4'h5,
      next_play      = 4'h6,
      next_round     = 4'h7,
      last_check     = 4'h8,
      wait_extra     = 4'h9,
      final_win      = 4'hA,
      register_extra = 4'hB,
      show           = 4'hC,
      final_error    = 4'hE,
      final_timeout  = 4'hF
   } state_t;

   // ----------------------------------------
   // Control to datapath
   // ----------------------------------------
   typedef struct packed {
      logic clear_play;
      logic count_play;
      logic clear_round;
      logic count_round;
      logic clear_guess;
      logic load_guess;
      logic write_seq;
      logic show_phase;
   } ctrl_t;

   // Datapath flags back to control
   typedef struct packed {
      logic press;
      logic match;
      logic round_end;
      logic game_end;
   } status_t;

endpackage

/* hw/sequence_memory.sv */
`timescale 1ns/10ps

module sequence_memory (
   input  logic                     clock,
   input  logic                     write,
   input  memory_game_pkg::index_t  addr,
   input  memory_game_pkg::button_t wdata,
   output memory_game_pkg::button_t rdata
);

   import memory_game_pkg::*;

   button_t mem [seq_depth];
   index_t  addr_q;

   // First entry of every game is fixed
   initial begin
      for (int i = 0; i < seq_depth; i++) begin
         mem[i] = '0;
      end
      mem[0] = 4'b0001;
   end

   always_ff @(posedge clock) begin
      if (write) begin
         mem[addr] <= wdata;
      end
      addr_q <= addr;
   end

   // Read through the registered address
   assign rdata = mem[addr_q];

endmodule

/* src.f */
+incdir+include
hw/memory_game_pkg.sv
hw/game_timer.sv
hw/sequence_memory.sv
hw/game_datapath.sv
hw/game_control.sv
hw/memory_game.sv
dv/memory_game_tb.sv
